// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - include_dirs:
      - .
    files:
      - cpuPkg.sv
      - instrLink.sv
      - instrFetch.sv
      - instrQueue.sv
      - instrDecode.sv
      - aluUnit.sv
      - execCore.sv
      - cpuTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpuTb.sv

// ==== aluUnit.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module aluUnit (
  input  cpuPkg::aluFuncT    func,
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  logic [3:0]         shamt,
  output logic [`DATA_W-1:0] result,
  output logic               zr,
  output logic               ne,
  output logic               ov
);
  import cpuPkg::*;

  logic [`DATA_W-1:0] sum;
  logic [`DATA_W-1:0] diff;
  logic               sumOv;
  logic               diffOv;

  assign sum  = a + b;
  assign diff = a - b;

  // Signed overflow, result sign disagrees with the operands
  assign sumOv  = (a[`DATA_W-1] == b[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
  assign diffOv = (a[`DATA_W-1] != b[`DATA_W-1]) && (diff[`DATA_W-1] != a[`DATA_W-1]);

  always_comb begin
    case (func)
      fnAdd: result = sum;
      // Immediate byte goes high, low byte of the source stays
      fnLhb: result = {b[7:0], a[7:0]};
      fnSub: result = diff;
      fnAnd: result = a & b;
      fnNor: result = ~(a | b);
      // Shifts work on port 1
      fnSll: result = b << shamt;
      fnSrl: result = b >> shamt;
      default: result = $signed(b) >>> shamt;
    endcase
  end

  assign zr = (result == '0);
  assign ne = result[`DATA_W-1];

  // Only add and subtract can overflow
  always_comb begin
    case (func)
      fnAdd:   ov = sumOv;
      fnSub:   ov = diffOv;
      default: ov = 1'b0;
    endcase
  end

endmodule

// ==== cpuPkg.sv ====
`include "cpu_config.svh"

package cpuPkg;

  localparam int REG_ADDR_W = $clog2(`REG_CNT);

  // Top nibble of the instruction
  typedef enum logic [3:0] {
    opAdd  = 4'b0000,
    opAddz = 4'b0001,
    opSub  = 4'b0010,
    opAnd  = 4'b0011,
    opNor  = 4'b0100,
    opSll  = 4'b0101,
    opSrl  = 4'b0110,
    opSra  = 4'b0111,
    opLw   = 4'b1000,
    opSw   = 4'b1001,
    opLhb  = 4'b1010,
    opLlb  = 4'b1011,
    opB    = 4'b1100,
    opJal  = 4'b1101,
    opJr   = 4'b1110,
    opHlt  = 4'b1111
  } opcodeT;

  // Slot 001 is free for LHB since ADDZ reuses the add path
  typedef enum logic [2:0] {
    fnAdd = 3'b000,
    fnLhb = 3'b001,
    fnSub = 3'b010,
    fnAnd = 3'b011,
    fnNor = 3'b100,
    fnSll = 3'b101,
    fnSrl = 3'b110,
    fnSra = 3'b111
  } aluFuncT;

  // Condition field of B, instr[11:9]
  typedef enum logic [2:0] {
    condNeq    = 3'b000,
    condEq     = 3'b001,
    condGt     = 3'b010,
    condLt     = 3'b011,
    condGte    = 3'b100,
    condLte    = 3'b101,
    condOvfl   = 3'b110,
    condUncond = 3'b111
  } branchCondT;

  // One fetched word travels with its own address
  typedef struct packed {
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] instr;
  } fetchWordT;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] p0Addr;
    logic [REG_ADDR_W-1:0] p1Addr;
    logic [REG_ADDR_W-1:0] dstAddr;
    logic [3:0]            shamt;
    aluFuncT               func;
    logic                  re0;
    logic                  re1;
    logic                  memRe;
    logic                  we;
    logic                  memWe;
    logic                  aluOp;
    logic                  src1Sel;
    logic                  memToReg;
    logic                  jal;
    logic                  jr;
    logic                  hlt;
    logic                  branch;
  } decodeCtrlT;

endpackage

// ==== cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTb;
  import cpuPkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int MEM_WORDS    = 256;
  // Budget per program word before the run is declared stuck
  localparam int CYCLES_PER_INSTR = 400;
  // Cycles watched after halt for stray writes
  localparam int QUIET_CYCLES = 20;

  logic                  clk;
  logic                  rstN;
  logic [`DATA_W-1:0]    imemAddr;
  logic [`DATA_W-1:0]    imemData;
  logic [`DATA_W-1:0]    dmemAddr;
  logic [`DATA_W-1:0]    dmemWdata;
  logic                  dmemWe;
  logic [`DATA_W-1:0]    dmemRdata;
  logic                  wbEn;
  logic [REG_ADDR_W-1:0] wbAddr;
  logic [`DATA_W-1:0]    wbData;
  logic                  halted;

  // Behavioral instruction and data memories
  logic [`DATA_W-1:0] imem [MEM_WORDS];
  logic [`DATA_W-1:0] dmem [MEM_WORDS];

  // Expected writebacks and stores, consumed in order
  logic [`DATA_W-1:0] expWAddr [$];
  logic [`DATA_W-1:0] expWData [$];
  logic [`DATA_W-1:0] expSAddr [$];
  logic [`DATA_W-1:0] expSData [$];

  int wIdx          = 0;
  int sIdx          = 0;
  int instrLines    = 0;
  int mismatchCount = 0;
  int failureCount  = 0;
  bit traceOk       = 1'b0;

  cpuTop dut_i (
    .clk       (clk),
    .rstN      (rstN),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWe    (dmemWe),
    .dmemRdata (dmemRdata),
    .wbEn      (wbEn),
    .wbAddr    (wbAddr),
    .wbData    (wbData),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic checkValue(input string name, input logic [`DATA_W-1:0] expected,
                            input logic [`DATA_W-1:0] observed);
    if (observed !== expected) begin
      mismatchCount++;
      $display("ERROR at %0t ns: %s expected %h observed %h",
               $time, name, expected, observed);
    end
  endtask

  task automatic finishRun();
    $display("Error count: %0d value mismatches, %0d other failures",
             mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // One letter per line, then two hex fields
  task automatic loadTrace();
    int                 fd;
    int                 n;
    bit                 ok;
    string              line;
    logic [7:0]         kind;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] v;
    ok = 1'b0;
    fd = $fopen("cpu_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open cpu_trace.txt for reading");
    end else begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Blank and comment lines carry nothing
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h", kind, a, v);
          if (n != 3) begin
            $display("Malformed trace line: %s", line);
            ok = 1'b0;
          end else begin
            case (kind)
              "I": begin
                imem[a[7:0]] = v;
                instrLines++;
              end
              "M": dmem[a[7:0]] = v;
              "W": begin
                expWAddr.push_back(a);
                expWData.push_back(v);
              end
              "S": begin
                expSAddr.push_back(a);
                expSData.push_back(v);
              end
              default: begin
                $display("Unknown trace line kind %c", kind);
                ok = 1'b0;
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end
    traceOk = ok;
  endtask

  // Memory answers follow the addresses, driven on the falling edge
  always @(negedge clk) begin
    imemData  = imem[imemAddr[7:0]];
    dmemRdata = dmem[dmemAddr[7:0]];
  end

  // Outputs are settled just before the rising edge
  always @(posedge clk) begin
    if (rstN) begin
      if (halted && (wbEn || dmemWe)) begin
        failureCount++;
        $display("A write was seen at %0t ns after the CPU halted", $time);
      end
      if (wbEn) begin
        if (wIdx < expWData.size()) begin
          checkValue("wbAddr", expWAddr[wIdx], `DATA_W'(wbAddr));
          checkValue("wbData", expWData[wIdx], wbData);
        end else begin
          failureCount++;
          $display("Unexpected write to r%0d at %0t ns beyond the expected sequence",
                   wbAddr, $time);
        end
        wIdx++;
      end
      if (dmemWe) begin
        if (sIdx < expSData.size()) begin
          checkValue("dmemAddr", expSAddr[sIdx], dmemAddr);
          checkValue("dmemWdata", expSData[sIdx], dmemWdata);
        end else begin
          failureCount++;
          $display("Unexpected store to %h at %0t ns beyond the expected sequence",
                   dmemAddr, $time);
        end
        sIdx++;
        // Store lands at the edge
        dmem[dmemAddr[7:0]] = dmemWdata;
      end
    end
  end

  initial begin
    rstN      = 1'b0;
    imemData  = '0;
    dmemRdata = '0;
    // Unused program words decode as HLT
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {4'hF, 4'h0, i[7:0]};
      dmem[i] = {~i[7:0], i[7:0]};
    end
    loadTrace();
    if (!traceOk) begin
      failureCount++;
      finishRun();
    end else begin
      repeat (RESET_CYCLES) @(negedge clk);
      rstN = 1'b1;
      // Watchdog bounds this wait
      wait (halted === 1'b1);
      repeat (QUIET_CYCLES) @(negedge clk);
      checkValue("halted", `DATA_W'(1), `DATA_W'(halted));
      if (wIdx < expWData.size()) begin
        failureCount++;
        $display("Only %0d of %0d expected register writes were seen",
                 wIdx, expWData.size());
      end
      if (sIdx < expSData.size()) begin
        failureCount++;
        $display("Only %0d of %0d expected stores were seen", sIdx, expSData.size());
      end
      finishRun();
    end
  end

  initial begin
    wait (traceOk);
    repeat (instrLines * CYCLES_PER_INSTR) @(posedge clk);
    failureCount++;
    $display("Timeout: the CPU did not halt within %0d cycles",
             instrLines * CYCLES_PER_INSTR);
    finishRun();
  end

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTop (
  input  logic                          clk,
  input  logic                          rstN,
  output logic [`DATA_W-1:0]            imemAddr,
  input  logic [`DATA_W-1:0]            imemData,
  output logic [`DATA_W-1:0]            dmemAddr,
  output logic [`DATA_W-1:0]            dmemWdata,
  output logic                          dmemWe,
  input  logic [`DATA_W-1:0]            dmemRdata,
  output logic                          wbEn,
  output logic [cpuPkg::REG_ADDR_W-1:0] wbAddr,
  output logic [`DATA_W-1:0]            wbData,
  output logic                          halted
);

  logic               redirect;
  logic [`DATA_W-1:0] redirectPc;

  // Fetch to queue, queue to execute
  instrLink fetchLink ();
  instrLink execLink ();

  instrFetch fetch_i (
    .clk        (clk),
    .rstN       (rstN),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .fetchLink  (fetchLink.producer)
  );

  // Redirect empties the queue
  instrQueue queue_i (
    .clk     (clk),
    .rstN    (rstN),
    .flush   (redirect),
    .inLink  (fetchLink.consumer),
    .outLink (execLink.producer)
  );

  execCore exec_i (
    .clk        (clk),
    .rstN       (rstN),
    .execLink   (execLink.consumer),
    .dmemAddr   (dmemAddr),
    .dmemWdata  (dmemWdata),
    .dmemWe     (dmemWe),
    .dmemRdata  (dmemRdata),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .wbEn       (wbEn),
    .wbAddr     (wbAddr),
    .wbData     (wbData),
    .halted     (halted)
  );

endmodule

// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of a data word and of an instruction word
`define DATA_W 16

// Register file size, register 0 is hardwired to zero
`define REG_CNT 16

// Entries in the instruction queue
`define QUEUE_DEPTH 4

// First fetch address after reset
`define RESET_PC 0

`endif

// ==== cpu_trace.txt ====
# I: instruction address, word   M: data address, initial word
# W: expected register, value    S: expected store address, value
I 0000 B105  LLB r1 05
I 0001 B2FD
I 0002 0312  ADD r3 r1 r2
I 0003 2412
I 0004 3512
I 0005 4612  NOR
I 0006 5724
I 0007 6824
I 0008 7924  SRA r9 r2 4
I 0009 A112
I 000A 9103  SW r1 to 3
I 000B 8A07  LW r10 from 7
I 000C 1B12  ADDZ with zero clear
I 000D 2011
I 000E 1B12
I 000F C001
I 0011 C201
I 0012 BC01
I 0013 C401
I 0015 C601
I 0016 BC02
I 0017 C801
I 0019 CA01
I 001A BC03
I 001B CC01
I 001C BC04
I 001D 2011  flags now zero
I 001E C001
I 001F BC05
I 0020 C201
I 0022 C401
I 0023 BC06
I 0024 CA01
I 0026 2021  flags now negative
I 0027 C601
I 0029 C801
I 002A BC07
I 002B A87F
I 002C 0088  signed overflow
I 002D CC01
I 002F CE01
I 0031 D002  JAL
I 0034 BE38
I 0035 E0E0  JR r14
I 0038 9CEE
I 0039 F000
I 003A BC09
M 0007 BEEF
W 1 0005
W 2 FFFD
W 3 0002
W 4 0008
W 5 0005
W 6 0002
W 7 FFD0
W 8 0FFF
W 9 FFFF
W 1 1205
W A BEEF
W B 1202
W C 0001
W C 0002
W C 0003
W C 0004
W C 0005
W C 0006
W C 0007
W 8 7FFF
W F 0032
W E 0038
S 0003 1205
S 0036 0007

// ==== execCore.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module execCore (
  input  logic                            clk,
  input  logic                            rstN,
  instrLink.consumer                      execLink,
  output logic [`DATA_W-1:0]              dmemAddr,
  output logic [`DATA_W-1:0]              dmemWdata,
  output logic                            dmemWe,
  input  logic [`DATA_W-1:0]              dmemRdata,
  output logic                            redirect,
  output logic [`DATA_W-1:0]              redirectPc,
  output logic                            wbEn,
  output logic [cpuPkg::REG_ADDR_W-1:0]   wbAddr,
  output logic [`DATA_W-1:0]              wbData,
  output logic                            halted
);
  import cpuPkg::*;

  logic [`DATA_W-1:0] rf [`REG_CNT];
  logic               zrQ;
  logic               neQ;
  logic               ovQ;
  decodeCtrlT         ctrl;
  logic [`DATA_W-1:0] nextPc;
  logic [`DATA_W-1:0] nextAddr;
  logic [`DATA_W-1:0] target;
  logic [`DATA_W-1:0] p0Data;
  logic [`DATA_W-1:0] p1Data;
  logic [`DATA_W-1:0] imm;
  logic [`DATA_W-1:0] aluB;
  logic [`DATA_W-1:0] aluResult;
  logic               aluZr;
  logic               aluNe;
  logic               aluOv;
  logic               retire;
  opcodeT             opcode;

  assign opcode = opcodeT'(execLink.word.instr[15:12]);
  assign nextPc = execLink.word.pc + 1'b1;

  instrDecode decode_i (
    .instr    (execLink.word.instr),
    .nextPc   (nextPc),
    .zr       (zrQ),
    .ne       (neQ),
    .ov       (ovQ),
    .ctrl     (ctrl),
    .nextAddr (nextAddr)
  );

  // Register 0 always reads as zero
  assign p0Data = (ctrl.re0 && ctrl.p0Addr != '0) ? rf[ctrl.p0Addr] : '0;
  assign p1Data = (ctrl.re1 && ctrl.p1Addr != '0) ? rf[ctrl.p1Addr] : '0;

  // Immediate layout depends on the opcode
  always_comb begin
    case (opcode)
      opLw, opSw: imm = {{(`DATA_W - 4){execLink.word.instr[3]}}, execLink.word.instr[3:0]};
      opLhb:      imm = {{(`DATA_W - 8){1'b0}}, execLink.word.instr[7:0]};
      opLlb:      imm = {execLink.word.instr[7:0], {(`DATA_W - 8){1'b0}}};
      default:    imm = '0;
    endcase
  end

  assign aluB = ctrl.src1Sel ? imm : p1Data;

  aluUnit alu_i (
    .func   (ctrl.func),
    .a      (p0Data),
    .b      (aluB),
    .shamt  (ctrl.shamt),
    .result (aluResult),
    .zr     (aluZr),
    .ne     (aluNe),
    .ov     (aluOv)
  );

  // Retire in the cycle ack goes up
  assign retire = execLink.req && !execLink.ack && !halted;

  assign wbData = ctrl.jal ? nextPc : ((ctrl.memToReg && ctrl.memRe) ? dmemRdata : aluResult);
  assign wbAddr = ctrl.dstAddr;
  assign wbEn   = retire && ctrl.we && (ctrl.dstAddr != '0);

  assign dmemAddr  = (ctrl.memRe || ctrl.memWe) ? aluResult : '0;
  assign dmemWdata = p1Data;
  assign dmemWe    = retire && ctrl.memWe;

  // JR jumps to the register, everything else uses the decoded address
  assign target     = ctrl.jr ? p0Data : nextAddr;
  assign redirectPc = target;
  assign redirect   = retire && (target != nextPc);

  always_ff @(posedge clk) begin
    if (wbEn) begin
      rf[wbAddr] <= wbData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      execLink.ack <= 1'b0;
      halted       <= 1'b0;
      {zrQ, neQ, ovQ} <= 3'b000;
    end else begin
      // Hold ack until the producer lets go of req
      execLink.ack <= execLink.ack ? execLink.req : retire;
      if (retire && ctrl.hlt) begin
        halted <= 1'b1;
      end
      // Flags only move on ALU ops
      if (retire && ctrl.aluOp) begin
        {zrQ, neQ, ovQ} <= {aluZr, aluNe, aluOv};
      end
    end
  end

  noR0Write: assert property (@(posedge clk) disable iff (!rstN)
    wbEn |-> wbAddr != '0);

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module instrDecode (
  input  logic [`DATA_W-1:0] instr,
  input  logic [`DATA_W-1:0] nextPc,
  input  logic               zr,
  input  logic               ne,
  input  logic               ov,
  output cpuPkg::decodeCtrlT ctrl,
  output logic [`DATA_W-1:0] nextAddr
);
  import cpuPkg::*;

  opcodeT             opcode;
  branchCondT         cond;
  logic               taken;
  logic               isShift;
  logic [`DATA_W-1:0] branchTarget;
  logic [`DATA_W-1:0] jalTarget;

  assign opcode = opcodeT'(instr[15:12]);
  assign cond   = branchCondT'(instr[11:9]);

  // SLL, SRL and SRA take their operand through port 1
  assign isShift = (opcode == opSll) || (opcode == opSrl) || (opcode == opSra);

  // Offsets are relative to the following instruction
  assign branchTarget = nextPc + {{(`DATA_W - 9){instr[8]}}, instr[8:0]};
  assign jalTarget    = nextPc + {{(`DATA_W - 12){instr[11]}}, instr[11:0]};

  // Branch condition from the flags of the last ALU op
  always_comb begin
    case (cond)
      condNeq:  taken = !zr;
      condEq:   taken = zr;
      condGt:   taken = !(zr || ne);
      condLt:   taken = ne;
      condGte:  taken = !ne;
      condLte:  taken = ne || zr;
      condOvfl: taken = ov;
      default:  taken = 1'b1;
    endcase
  end

  always_comb begin
    ctrl.branch = (opcode == opB);
    ctrl.jal    = (opcode == opJal);
    ctrl.jr     = (opcode == opJr);
    ctrl.hlt    = (opcode == opHlt);

    // Plain ALU ops have a zero top bit
    ctrl.aluOp   = !instr[15];
    ctrl.src1Sel = instr[15];

    // LHB reads back its own destination to keep the low byte
    ctrl.p0Addr = (opcode == opLhb) ? instr[11:8] : instr[7:4];

    // Store data comes from the rt field
    if (opcode == opSw) begin
      ctrl.p1Addr = instr[11:8];
    end else if (isShift) begin
      ctrl.p1Addr = instr[7:4];
    end else begin
      ctrl.p1Addr = instr[3:0];
    end

    // JAL links into r15, a failed ADDZ is steered to r0
    if (ctrl.jal) begin
      ctrl.dstAddr = REG_ADDR_W'(`REG_CNT - 1);
    end else if (opcode == opAddz && !zr) begin
      ctrl.dstAddr = '0;
    end else begin
      ctrl.dstAddr = instr[11:8];
    end

    // LLB shifts the placed byte back down by 8
    ctrl.shamt = !instr[15] ? instr[3:0] : 4'd8;

    ctrl.re0      = !ctrl.hlt;
    ctrl.re1      = !ctrl.hlt;
    ctrl.memRe    = (opcode == opLw);
    ctrl.memToReg = (opcode == opLw);
    ctrl.memWe    = (opcode == opSw);
    ctrl.we       = ctrl.aluOp || ctrl.jal || (opcode == opLw)
                    || (opcode == opLhb) || (opcode == opLlb);

    // ALU ops pass their low opcode bits, ADDZ runs as add
    if (ctrl.aluOp) begin
      ctrl.func = (opcode == opAddz) ? fnAdd : aluFuncT'(instr[14:12]);
    end else if (opcode == opLhb) begin
      ctrl.func = fnLhb;
    end else if (opcode == opLlb) begin
      ctrl.func = fnSra;
    end else begin
      // LW and SW add the offset to the base
      ctrl.func = fnAdd;
    end
  end

  // Not-taken branch falls through
  always_comb begin
    if (ctrl.branch && taken) begin
      nextAddr = branchTarget;
    end else if (ctrl.jal) begin
      nextAddr = jalTarget;
    end else begin
      nextAddr = nextPc;
    end
  end

endmodule

// ==== instrFetch.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module instrFetch (
  input  logic               clk,
  input  logic               rstN,
  input  logic               redirect,
  input  logic [`DATA_W-1:0] redirectPc,
  output logic [`DATA_W-1:0] imemAddr,
  input  logic [`DATA_W-1:0] imemData,
  instrLink.producer         fetchLink
);
  import cpuPkg::*;

  logic [`DATA_W-1:0] pc;
  // Word handed over, waiting for ack to fall before moving on
  logic               sent;
  logic               raise;

  // Memory is addressed straight from the pc, so a stall holds the address
  assign imemAddr = pc;

  // Open a new transfer only from a fully idle link
  assign raise = !redirect && !fetchLink.req && !fetchLink.ack && !sent;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc            <= `DATA_W'(`RESET_PC);
      fetchLink.req <= 1'b0;
      sent          <= 1'b0;
    end else if (redirect) begin
      // Abandon whatever is open and restart at the target
      pc            <= redirectPc;
      fetchLink.req <= 1'b0;
      sent          <= 1'b0;
    end else if (fetchLink.req) begin
      if (fetchLink.ack) begin
        fetchLink.req <= 1'b0;
        sent          <= 1'b1;
      end
    end else if (!fetchLink.ack) begin
      if (sent) begin
        // Ack has fallen, handshake complete
        pc   <= pc + 1'b1;
        sent <= 1'b0;
      end else begin
        fetchLink.req <= 1'b1;
      end
    end
  end

  // Capture the instruction together with its address
  always_ff @(posedge clk) begin
    if (raise) begin
      fetchLink.word.pc    <= pc;
      fetchLink.word.instr <= imemData;
    end
  end

  // Word is held for the whole time req is up
  wordStable: assert property (@(posedge clk) disable iff (!rstN)
    fetchLink.req |=> !fetchLink.req || $stable(fetchLink.word));

endmodule

// ==== instrLink.sv ====
`timescale 1ns/1ps

interface instrLink;
  import cpuPkg::*;

  // Four-phase handshake, req and word from the producer
  logic      req;
  logic      ack;
  fetchWordT word;

  modport producer (
    output req,
    output word,
    input  ack
  );

  modport consumer (
    input  req,
    input  word,
    output ack
  );

endinterface

// ==== instrQueue.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module instrQueue (
  input  logic       clk,
  input  logic       rstN,
  input  logic       flush,
  instrLink.consumer inLink,
  instrLink.producer outLink
);
  import cpuPkg::*;

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  fetchWordT          mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0]   wrPtr;
  logic [PTR_W-1:0]   rdPtr;
  logic [CNT_W-1:0]   count;
  logic               full;
  logic               write;
  logic               pop;

  assign full = (count == CNT_W'(`QUEUE_DEPTH));

  // Take a word on the rising side of req, never during a flush
  assign write = inLink.req && !inLink.ack && !full && !flush;
  // Consumer ack on an open req frees the head entry
  assign pop = outLink.req && outLink.ack;

  // Head entry is the offered word, it cannot move while req is up
  assign outLink.word = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wrPtr] <= inLink.word;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inLink.ack  <= 1'b0;
      outLink.req <= 1'b0;
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
    end else begin
      // Input side, ack follows req back down
      if (inLink.ack) begin
        inLink.ack <= inLink.req;
      end else begin
        inLink.ack <= write;
      end
      if (flush) begin
        wrPtr       <= '0;
        rdPtr       <= '0;
        count       <= '0;
        outLink.req <= 1'b0;
      end else begin
        if (write) begin
          wrPtr <= (wrPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
        end
        if (pop) begin
          rdPtr       <= (rdPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
          outLink.req <= 1'b0;
        end else if (!outLink.req && !outLink.ack && count != '0) begin
          // Offer only once the previous ack is gone
          outLink.req <= 1'b1;
        end
        case ({write, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end
  end

  noOverflow: assert property (@(posedge clk) disable iff (!rstN)
    count <= CNT_W'(`QUEUE_DEPTH));

  // An offered word must still be held when it is taken
  noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
    pop && !flush |-> count != '0);

endmodule

// ==== project.f ====
+incdir+.
cpuPkg.sv
instrLink.sv
instrFetch.sv
instrQueue.sv
instrDecode.sv
aluUnit.sv
execCore.sv
cpuTop.sv
cpuTb.sv
